// ==== src/nocFlitPkg.sv ====
`default_nettype none

package nocFlitPkg;

  // width of the payload carried by every flit.
  localparam int FLIT_DATA_W = 16;

  // a header payload holds the packet length in its low bits.
  localparam int LENGTH_W = 12;

  typedef logic [FLIT_DATA_W-1:0] flitDataT;

  // Kind of flit on a channel.
  typedef enum logic [2:0]
  {
    FLIT_NONE   = 3'd0,  // no flit on the channel.
    FLIT_HEADER = 3'd1,  // first flit, low bits give the packet length.
    FLIT_BODY   = 3'd2,
    FLIT_TAIL   = 3'd3   // last flit of the packet.
  } flitKindE;

endpackage

`default_nettype wire

// ==== src/arbPkg.sv ====
`default_nettype none

package arbPkg;

  import nocFlitPkg::*;

  localparam int NUM_PORTS = 5;

  // mesh ports, listed in the cyclic search order.
  typedef enum logic [2:0]
  {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portE;

  typedef enum logic [2:0]
  {
    GRANT_IDLE = 3'd0,
    GRANT_L    = 3'd1,
    GRANT_N    = 3'd2,
    GRANT_E    = 3'd3,
    GRANT_W    = 3'd4,
    GRANT_S    = 3'd5
  } grantStateE;

  typedef logic [LENGTH_W-1:0] holdCountT;   // sized to count up to any header length.
  typedef logic [NUM_PORTS-1:0] portMaskT;

  // Port that owns the output in a grant state, only meaningful outside idle.
  function automatic portE ownerOf(grantStateE state);
    case (state)
      GRANT_N: return PORT_N;
      GRANT_E: return PORT_E;
      GRANT_W: return PORT_W;
      GRANT_S: return PORT_S;
      default: return PORT_L;
    endcase
  endfunction

  function automatic grantStateE grantOf(portE port);
    case (port)
      PORT_L:  return GRANT_L;
      PORT_N:  return GRANT_N;
      PORT_E:  return GRANT_E;
      PORT_W:  return GRANT_W;
      PORT_S:  return GRANT_S;
      default: return GRANT_IDLE;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== src/flitChannel.sv ====
`timescale 1ns/1ps
`default_nettype none

interface flitChannel
  import nocFlitPkg::*;
();

  logic     valid;
  logic     ready;
  flitKindE kind;
  flitDataT data;   // kind and data stay put while valid waits for ready.

  modport source
  (
    output valid,
    output kind,
    output data,
    input  ready
  );

  modport sink
  (
    input  valid,
    input  kind,
    input  data,
    output ready
  );

  // observes the handshake without taking part in it.
  modport monitor
  (
    input valid,
    input ready,
    input kind,
    input data
  );

endinterface

`default_nettype wire

// ==== src/holdTimerBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module holdTimerBank
  import nocFlitPkg::*;
  import arbPkg::*;
(
  input  logic               clk,
  input  logic               rst,
  flitChannel.monitor        inCh [NUM_PORTS],
  input  portMaskT           runTimer,
  output portMaskT           timesUp
);

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gTimer
    holdCountT holdLimit;
    holdCountT holdCount;
    logic      headerSeen;

    // the limit follows any visible header, transferred or not.
    assign headerSeen = inCh[p].valid && (inCh[p].kind == FLIT_HEADER);

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        holdLimit <= '0;  // a zero limit gives a one-cycle grant.
        holdCount <= '0;
      end
      else
      begin
        if (headerSeen)
        begin
          holdLimit <= inCh[p].data[LENGTH_W-1:0];
        end
        if (runTimer[p])
        begin
          holdCount <= holdCount + 1'b1;
        end
        else
        begin
          holdCount <= '0;  // restarts for every new grant.
        end
      end
    end

    assign timesUp[p] = (holdCount == holdLimit);
  end

endmodule

`default_nettype wire

// ==== src/rotatePicker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rotatePicker
  import arbPkg::*;
(
  input  grantStateE state,
  input  portMaskT   request,
  output portE       nextPort,
  output logic       anyRequest
);

  portE startAfter;

  // idle searches as if S had just owned the port, so L comes first.
  assign startAfter = (state == GRANT_IDLE) ? PORT_S : ownerOf(state);

  // Walk the ring backwards so the first requester after the owner wins.
  always_comb
  begin
    int idx;
    nextPort = PORT_L;
    for (int off = NUM_PORTS; off >= 1; off--)
    begin
      idx = int'(startAfter) + off;
      if (idx >= NUM_PORTS)
      begin
        idx = idx - NUM_PORTS;
      end
      if (request[idx])
      begin
        nextPort = portE'(idx[2:0]);  // the owner itself sits at off equal to NUM_PORTS.
      end
    end
  end

  assign anyRequest = |request;

endmodule

`default_nettype wire

// ==== src/grantFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantFsm
  import arbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portMaskT   request,
  input  portMaskT   timesUp,
  input  portE       nextPort,
  input  logic       anyRequest,
  output grantStateE state,
  output portMaskT   runTimer
);

  grantStateE nextState;
  portE       owner;
  logic       keepGrant;

  assign owner = ownerOf(state);

  // the owner stays while it still asks and its hold budget is left.
  assign keepGrant = (state != GRANT_IDLE) && request[owner] && !timesUp[owner];

  always_comb
  begin
    runTimer = '0;
    if (keepGrant)
    begin
      runTimer[owner] = 1'b1;
      nextState = state;
    end
    else if (anyRequest)
    begin
      nextState = grantOf(nextPort);  // may hand the port straight back to the owner.
    end
    else
    begin
      nextState = GRANT_IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= GRANT_IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

endmodule

`default_nettype wire

// ==== src/flitSwitch.sv ====
`timescale 1ns/1ps
`default_nettype none

module flitSwitch
  import nocFlitPkg::*;
  import arbPkg::*;
(
  input  grantStateE  state,
  flitChannel.sink    inCh [NUM_PORTS],
  flitChannel.source  outCh
);

  portE     sel;
  logic     idle;
  portMaskT owned;
  portMaskT chValid;
  flitKindE chKind [NUM_PORTS];
  flitDataT chData [NUM_PORTS];

  assign idle = (state == GRANT_IDLE);
  assign sel  = ownerOf(state);

  always_comb
  begin
    owned = '0;
    if (!idle)
    begin
      owned[sel] = 1'b1;
    end
  end

  // interface arrays take constant indices only, so flatten them here.
  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gFlatten
    assign chValid[p]  = inCh[p].valid;
    assign chKind[p]   = inCh[p].kind;
    assign chData[p]   = inCh[p].data;
    assign inCh[p].ready = owned[p] && outCh.ready;  // losers see no ready.
  end

  assign outCh.valid = !idle && chValid[sel];
  assign outCh.kind  = idle ? FLIT_NONE : chKind[sel];
  assign outCh.data  = idle ? '0 : chData[sel];

endmodule

`default_nettype wire

// ==== src/outPortAllocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module outPortAllocator
  import nocFlitPkg::*;
  import arbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  portMaskT   inValid,
  output portMaskT   inReady,
  input  flitKindE   inKind [NUM_PORTS],
  input  flitDataT   inData [NUM_PORTS],
  output logic       outValid,
  input  logic       outReady,
  output flitKindE   outKind,
  output flitDataT   outData,
  output grantStateE outSource
);

  grantStateE state;
  portMaskT   runTimer;
  portMaskT   timesUp;
  portE       nextPort;
  logic       anyRequest;

  flitChannel inCh [NUM_PORTS] ();
  flitChannel outCh ();

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : gInputs
    assign inCh[p].valid = inValid[p];
    assign inCh[p].kind  = inKind[p];
    assign inCh[p].data  = inData[p];
    assign inReady[p]    = inCh[p].ready;
  end

  assign outValid     = outCh.valid;
  assign outKind      = outCh.kind;
  assign outData      = outCh.data;
  assign outCh.ready  = outReady;
  assign outSource    = state;  // tags the origin of the flit on the output link.

  holdTimerBank uHoldTimerBank
  (
    .clk      (clk),
    .rst      (rst),
    .inCh     (inCh),
    .runTimer (runTimer),
    .timesUp  (timesUp)
  );

  rotatePicker uRotatePicker
  (
    .state      (state),
    .request    (inValid),
    .nextPort   (nextPort),
    .anyRequest (anyRequest)
  );

  grantFsm uGrantFsm
  (
    .clk        (clk),
    .rst        (rst),
    .request    (inValid),
    .timesUp    (timesUp),
    .nextPort   (nextPort),
    .anyRequest (anyRequest),
    .state      (state),
    .runTimer   (runTimer)
  );

  flitSwitch uFlitSwitch
  (
    .state (state),
    .inCh  (inCh),
    .outCh (outCh)
  );

endmodule

`default_nettype wire

// ==== dv/outPortAllocatorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module outPortAllocatorTb
  import nocFlitPkg::*;
  import arbPkg::*;
();

  localparam int VEC_WORDS    = 17;  // words on one line of the vector file.
  localparam int MAX_VECTORS  = 64;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;

  logic       clk;
  logic       rst;
  portMaskT   inValid;
  portMaskT   inReady;
  flitKindE   inKind [NUM_PORTS];
  flitDataT   inData [NUM_PORTS];
  logic       outValid;
  logic       outReady;
  flitKindE   outKind;
  flitDataT   outData;
  grantStateE outSource;

  logic [15:0] vecMem [0:VEC_WORDS*MAX_VECTORS-1];
  int          vecCount;
  logic        vecLoaded;
  string       where;

  outPortAllocator uut
  (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inReady   (inReady),
    .inKind    (inKind),
    .inData    (inData),
    .outValid  (outValid),
    .outReady  (outReady),
    .outKind   (outKind),
    .outData   (outData),
    .outSource (outSource)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "run stopped at %s", where);
  endtask

  task automatic checkFlit(input logic expValid, input flitKindE expKind, input flitDataT expData);
    if (outValid !== expValid)
    begin
      stopRun($sformatf("Mismatch outValid at %s: expected %h, got %h",
                        where, expValid, outValid));
    end
    if (outKind !== expKind)
    begin
      stopRun($sformatf("Mismatch outKind at %s: expected %h, got %h", where, expKind, outKind));
    end
    if (outData !== expData)
    begin
      stopRun($sformatf("Mismatch outData at %s: expected %h, got %h", where, expData, outData));
    end
  endtask

  task automatic checkSource(input grantStateE expSource);
    if (outSource !== expSource)
    begin
      stopRun($sformatf("Mismatch outSource at %s: expected %h, got %h",
                        where, expSource, outSource));
    end
  endtask

  task automatic checkReady(input portMaskT expReady);
    if (inReady !== expReady)
    begin
      stopRun($sformatf("Mismatch inReady at %s: expected %h, got %h", where, expReady, inReady));
    end
  endtask

  task automatic loadVectors();
    int i;
    for (i = 0; i < VEC_WORDS*MAX_VECTORS; i++)
    begin
      vecMem[i] = 'x;  // unloaded words stay unknown and mark the end of the file.
    end
    $readmemh("dv/allocatorVectors.txt", vecMem);
    vecCount = 0;
    while (vecCount < MAX_VECTORS && vecMem[vecCount*VEC_WORDS] !== 'x)
    begin
      vecCount++;
    end
    if (vecCount == 0)
    begin
      stopRun("the vector file could not be read or holds no vectors");
    end
    if (vecMem[vecCount*VEC_WORDS - 1] === 'x)
    begin
      stopRun("the vector file ends in the middle of a line");
    end
  endtask

  task automatic applyVector(input int v);
    int base;
    int p;
    base = v * VEC_WORDS;
    inValid = portMaskT'(vecMem[base]);
    for (p = 0; p < NUM_PORTS; p++)
    begin
      inKind[p] = flitKindE'(vecMem[base + 1 + p][2:0]);
      inData[p] = vecMem[base + 6 + p];
    end
    outReady = vecMem[base + 11][0];
  endtask

  task automatic checkVector(input int v);
    int base;
    base = v * VEC_WORDS + 12;  // expected values follow the twelve input words.
    checkFlit(vecMem[base][0], flitKindE'(vecMem[base + 2][2:0]), vecMem[base + 3]);
    checkSource(grantStateE'(vecMem[base + 1][2:0]));
    checkReady(portMaskT'(vecMem[base + 4]));
  endtask

  initial
  begin
    int p;
    int c;
    int v;
    clk = 1'b0;
    rst = 1'b1;
    inValid = '1;  // requests and ready during reset must not reach the output.
    outReady = 1'b1;
    for (p = 0; p < NUM_PORTS; p++)
    begin
      inKind[p] = FLIT_BODY;
      inData[p] = flitDataT'(16'h1111 * (p + 1));
    end
    vecLoaded = 1'b0;
    where = "vector load";
    loadVectors();
    vecLoaded = 1'b1;
    for (c = 0; c < RESET_CYCLES; c++)
    begin
      @(posedge clk);
      #5;
      where = $sformatf("reset cycle %0d", c);
      checkFlit(1'b0, FLIT_NONE, '0);
      checkSource(GRANT_IDLE);
      checkReady('0);
    end
    for (v = 0; v < vecCount; v++)
    begin
      @(negedge clk);
      rst = 1'b0;
      where = $sformatf("vector %0d", v);
      applyVector(v);
      #(CLK_PERIOD/2 - 2);  // sample just ahead of the next rising edge.
      checkVector(v);
    end
    $display("test passed");
    $finish;
  end

  // Watchdog, twice the time that reset and all vectors need.
  initial
  begin
    wait (vecLoaded === 1'b1);
    #((vecCount + RESET_CYCLES) * CLK_PERIOD * 2);
    where = "watchdog expiry";
    stopRun("the run did not finish before the watchdog limit");
  end

endmodule

`default_nettype wire

// ==== dv/allocatorVectors.txt ====
// inValid kindL kindN kindE kindW kindS dataL dataN dataE dataW dataS outReady
// then expected outValid outSource outKind outData inReady, all hex, one cycle per line
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 0 0 0000 00
00 0 0 0 0 0 0000 0000 0000 0000 0000 0 0 0 0 0000 00
1c 0 0 1 2 3 0000 0000 e000 3b01 4c02 1 0 0 0 0000 00
1c 0 0 1 2 3 0000 0000 e000 3b01 4c02 1 1 3 1 e000 04
18 0 0 0 2 3 0000 0000 0000 3b01 4c02 1 1 4 2 3b01 08
10 0 0 0 0 3 0000 0000 0000 0000 4c02 1 1 5 3 4c02 10
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 5 0 0000 10
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 0 0 0000 00
1f 2 2 2 2 2 1111 2222 3333 4444 5555 1 0 0 0 0000 00
1f 2 2 2 2 2 1111 2222 3333 4444 5555 1 1 1 2 1111 01
1f 2 2 2 2 2 1111 2222 3333 4444 5555 1 1 2 2 2222 02
1f 2 1 2 2 2 1111 2003 3333 4444 5555 1 1 3 2 3333 04
1f 2 1 2 2 2 1111 2003 3333 4444 5555 1 1 4 2 4444 08
1f 2 1 2 2 2 1111 2003 3333 4444 5555 1 1 5 2 5555 10
1f 2 1 2 2 2 1111 2003 3333 4444 5555 1 1 1 2 1111 01
1f 2 1 2 2 2 1111 2003 3333 4444 5555 1 1 2 1 2003 02
1f 2 2 2 2 2 1111 2b01 3333 4444 5555 1 1 2 2 2b01 02
1f 2 2 2 2 2 1111 2b02 3333 4444 5555 1 1 2 2 2b02 02
1f 2 3 2 2 2 1111 2b03 3333 4444 5555 1 1 2 3 2b03 02
1d 2 0 2 2 2 1111 0000 3333 4444 5555 1 1 3 2 3333 04
19 2 0 0 2 2 1111 0000 0000 4444 5555 1 1 4 2 4444 08
11 2 0 0 0 2 1111 0000 0000 0000 5555 1 1 5 2 5555 10
03 2 1 0 0 0 1111 2005 0000 0000 0000 1 1 1 2 1111 01
02 0 1 0 0 0 0000 2005 0000 0000 0000 1 1 2 1 2005 02
06 0 2 2 0 0 0000 2c01 3a01 0000 0000 1 1 2 2 2c01 02
05 2 0 2 0 0 1a01 0000 3a01 0000 0000 1 0 2 0 0000 02
05 2 0 2 0 0 1a01 0000 3a01 0000 0000 1 1 3 2 3a01 04
01 2 0 0 0 0 1a01 0000 0000 0000 0000 1 1 1 2 1a01 01
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 1 0 0000 01
02 0 1 0 0 0 0000 2004 0000 0000 0000 1 0 0 0 0000 00
02 0 1 0 0 0 0000 2004 0000 0000 0000 1 1 2 1 2004 02
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 2 0 0000 02
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 0 0 0000 00
08 0 0 0 1 0 0000 0000 0000 4002 0000 0 0 0 0 0000 00
18 0 0 0 1 2 0000 0000 0000 4002 5a01 0 1 4 1 4002 00
18 0 0 0 1 2 0000 0000 0000 4002 5a01 0 1 4 1 4002 00
18 0 0 0 1 2 0000 0000 0000 4002 5a01 1 1 4 1 4002 08
18 0 0 0 2 2 0000 0000 0000 4b01 5a01 0 1 5 2 5a01 00
18 0 0 0 2 2 0000 0000 0000 4b01 5a01 1 1 4 2 4b01 08
18 0 0 0 3 2 0000 0000 0000 4b02 5a01 1 1 4 3 4b02 08
10 0 0 0 0 2 0000 0000 0000 0000 5a01 1 0 4 0 0000 08
10 0 0 0 0 2 0000 0000 0000 0000 5a01 1 1 5 2 5a01 10
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 5 0 0000 10
00 0 0 0 0 0 0000 0000 0000 0000 0000 1 0 0 0 0000 00

// ==== outPortAllocator.f ====
src/nocFlitPkg.sv
src/arbPkg.sv
src/flitChannel.sv
src/holdTimerBank.sv
src/rotatePicker.sv
src/grantFsm.sv
src/flitSwitch.sv
src/outPortAllocator.sv
dv/outPortAllocatorTb.sv

// ==== Bender.yml ====
package:
  name: outPortAllocator

sources:
  - src/nocFlitPkg.sv
  - src/arbPkg.sv
  - src/flitChannel.sv
  - src/holdTimerBank.sv
  - src/rotatePicker.sv
  - src/grantFsm.sv
  - src/flitSwitch.sv
  - src/outPortAllocator.sv
  - target: test
    files:
      - dv/outPortAllocatorTb.sv
